// ==== design/pi_com_pkg.sv ====
// PET bridge shared types
`default_nettype none

package pi_com_pkg;

    // Full PET bus address, including A16 from the command byte.
    typedef logic [16:0] bus_addr_t;

    // One data byte on the PET bus.
    typedef logic [7:0] bus_data_t;

    // One byte on the SPI link.
    // Command and address bytes travel here too.
    typedef logic [7:0] spi_byte_t;

    // Command code field, bits 5..0 of the command byte.
    typedef logic [5:0] pi_cmd_t;

    // Single byte memory access.
    localparam pi_cmd_t CMD_ACCESS = 6'd0;

    // Sequencer states.
    typedef enum logic [2:0] {
        IDLE,
        READ_CMD,
        READING_ARGS,
        COMPLETING,
        DONE,
        IGNORED
    } com_state_t;

endpackage

`default_nettype wire

// ==== design/spi_buffer.sv ====
// SPI byte buffer
`timescale 1ns/100ps
`default_nettype none

module spi_buffer import pi_com_pkg::*; (
    input  logic       rst_n,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_rx,
    output logic       spi_tx,
    input  logic [2:0] length,
    input  logic       tx_load,
    input  spi_byte_t  tx_byte,
    output spi_byte_t  rx0,
    output spi_byte_t  rx1,
    output spi_byte_t  rx2,
    output spi_byte_t  rx3,
    output logic       valid
);

    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;
    logic [6:0] rx_shift;
    spi_byte_t  tx_shift;
    logic       frame_rst_n;

    // Counters restart whenever the host deselects the device.
    assign frame_rst_n = rst_n & ~spi_cs_n;

    always_ff @(posedge spi_sclk or negedge frame_rst_n) begin
        if (!frame_rst_n) begin
            bit_cnt  <= 3'd0;
            byte_cnt <= 3'd0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
            // Saturate so that extra bytes do not wrap back to rx0.
            if (bit_cnt == 3'd7 && byte_cnt != 3'd4) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    // Mode 0 sampling, MSB first.
    always_ff @(posedge spi_sclk) begin
        if (!spi_cs_n) begin
            rx_shift <= {rx_shift[5:0], spi_rx};
            if (bit_cnt == 3'd7) begin
                case (byte_cnt)
                    3'd0:    rx0 <= {rx_shift, spi_rx};
                    3'd1:    rx1 <= {rx_shift, spi_rx};
                    3'd2:    rx2 <= {rx_shift, spi_rx};
                    3'd3:    rx3 <= {rx_shift, spi_rx};
                    default: ;
                endcase
            end
        end
    end

    // A length of zero means the sequencer is not waiting for anything.
    assign valid = (length != 3'd0) && (byte_cnt >= length);

    // Transmit byte is loaded between frames and shifted out during one.
    always_ff @(negedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
        end else if (spi_cs_n) begin
            if (tx_load) begin
                tx_shift <= tx_byte;
            end
        end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_tx = spi_cs_n ? 1'b0 : tx_shift[7];

endmodule

`default_nettype wire

// ==== design/pi_com.sv ====
// SPI command sequencer
`timescale 1ns/100ps
`default_nettype none

module pi_com import pi_com_pkg::*; (
    input  logic       rst_n,
    input  logic       spi_sclk,
    input  logic       pi_pending_in,
    input  logic       valid,
    input  spi_byte_t  rx0,
    input  spi_byte_t  rx1,
    input  spi_byte_t  rx2,
    input  spi_byte_t  rx3,
    input  logic       pi_done_in,
    input  bus_data_t  rd_data,
    output logic [2:0] length,
    output logic       tx_load,
    output spi_byte_t  tx_byte,
    output bus_addr_t  pi_addr,
    output bus_data_t  pi_data_out,
    output logic       pi_rw_b,
    output logic       pi_pending_out,
    output logic       pi_done_out
);

    localparam logic [2:0] LEN_NONE  = 3'd0;
    localparam logic [2:0] LEN_CMD   = 3'd1;
    localparam logic [2:0] LEN_READ  = 3'd3;
    localparam logic [2:0] LEN_WRITE = 3'd4;

    com_state_t state;
    com_state_t next_state;
    logic       seq_rst_n;
    logic       cmd_rw_b;
    logic       cmd_a16;
    pi_cmd_t    cmd_code;
    logic       enter_completing;
    logic       enter_done;

    // Command byte fields.
    assign cmd_rw_b = rx0[7];
    assign cmd_a16  = rx0[6];
    assign cmd_code = rx0[5:0];

    // Dropping the arm level aborts whatever is in progress.
    assign seq_rst_n = rst_n & pi_pending_in;

    assign enter_completing = (state == READING_ARGS) && (next_state == COMPLETING);
    assign enter_done       = (state == COMPLETING) && (next_state == DONE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (pi_pending_in) begin
                    next_state = READ_CMD;
                end
            end
            READ_CMD: begin
                if (valid) begin
                    next_state = (cmd_code == CMD_ACCESS) ? READING_ARGS : IGNORED;
                end
            end
            READING_ARGS: begin
                if (valid) begin
                    next_state = COMPLETING;
                end
            end
            COMPLETING: begin
                // Host may clock here as long as it likes.
                if (pi_done_in) begin
                    next_state = DONE;
                end
            end
            DONE:    next_state = DONE;
            IGNORED: next_state = IGNORED;
            default: next_state = IDLE;
        endcase
    end

    // State steps on the falling edge, away from the sampling edge.
    always_ff @(negedge spi_sclk or negedge seq_rst_n) begin
        if (!seq_rst_n) begin
            state          <= IDLE;
            length         <= LEN_NONE;
            pi_pending_out <= 1'b0;
            pi_done_out    <= 1'b0;
        end else begin
            state <= next_state;
            case (next_state)
                IDLE:         length <= LEN_NONE;
                READ_CMD:     length <= LEN_CMD;
                READING_ARGS: length <= cmd_rw_b ? LEN_READ : LEN_WRITE;
                IGNORED:      length <= LEN_NONE;
                default:      ;
            endcase
            if (enter_completing) begin
                pi_pending_out <= 1'b1;
            end
            if (enter_done) begin
                pi_done_out <= 1'b1;
            end
        end
    end

    // Bus request fields, stable before pending reaches the system clock.
    always_ff @(negedge spi_sclk) begin
        if (enter_completing) begin
            pi_addr     <= {cmd_a16, rx1, rx2};
            pi_data_out <= rx3;
        end
    end

    // Read result and direction outlive the arm level.
    always_ff @(negedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            pi_rw_b <= 1'b1;
            tx_byte <= '0;
            tx_load <= 1'b0;
        end else begin
            if (enter_completing) begin
                pi_rw_b <= cmd_rw_b;
            end
            if (enter_done) begin
                tx_load <= 1'b1;
                if (pi_rw_b) begin
                    tx_byte <= rd_data;
                end
            end else if (state == IDLE && next_state == READ_CMD) begin
                // Load window closes once a new transaction starts.
                tx_load <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_target.sv ====
// PET bus access target
`timescale 1ns/100ps
`default_nettype none

module bus_target import pi_com_pkg::*; #(
    parameter int RAM_ADDR_W = 17
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pi_pending_out,
    input  logic                  pi_rw_b,
    input  bus_addr_t             pi_addr,
    input  bus_data_t             pi_data_out,
    input  bus_data_t             ram_rd_data,
    output logic                  bus_done,
    output bus_data_t             rd_data,
    output logic                  ram_we,
    output logic [RAM_ADDR_W-1:0] ram_addr,
    output bus_data_t             ram_wr_data
);

    logic pend_meta;
    logic pend_sync;
    logic pend_prev;
    logic start;
    logic capture;

    // Two flop synchronizer plus one stage for edge detection.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_meta <= 1'b0;
            pend_sync <= 1'b0;
            pend_prev <= 1'b0;
        end else begin
            pend_meta <= pi_pending_out;
            pend_sync <= pend_meta;
            pend_prev <= pend_sync;
        end
    end

    assign start = pend_sync & ~pend_prev;

    // Request fields settled long before the synchronized edge.
    assign ram_we      = start & ~pi_rw_b;
    assign ram_addr    = pi_addr[RAM_ADDR_W-1:0];
    assign ram_wr_data = pi_data_out;

    // RAM output is valid the cycle after start.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capture <= 1'b0;
        end else begin
            capture <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (capture && pi_rw_b) begin
            rd_data <= ram_rd_data;
        end
    end

    // Done is held until the request is withdrawn.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_done <= 1'b0;
        end else if (!pend_sync) begin
            bus_done <= 1'b0;
        end else if (capture) begin
            bus_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/pet_ram.sv ====
// PET memory model
`timescale 1ns/100ps
`default_nettype none

module pet_ram import pi_com_pkg::*; #(
    parameter int RAM_ADDR_W = 17
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [RAM_ADDR_W-1:0] addr,
    input  bus_data_t             wr_data,
    output bus_data_t             rd_data
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    bus_data_t mem [DEPTH];

    // Synchronous write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    // Registered read, old data on a simultaneous write.
    always_ff @(posedge clk) begin
        rd_data <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== design/pi_bridge_top.sv ====
// PET host bridge top level
`timescale 1ns/100ps
`default_nettype none

module pi_bridge_top import pi_com_pkg::*; #(
    parameter int RAM_ADDR_W = 17
) (
    input  logic clk,
    input  logic rst_n,
    input  logic spi_sclk,
    input  logic spi_cs_n,
    input  logic spi_rx,
    output logic spi_tx,
    input  logic pi_pending_in,
    output logic pi_done_out
);

    // SPI side.
    logic [2:0] length;
    logic       valid;
    logic       tx_load;
    spi_byte_t  tx_byte;
    spi_byte_t  rx0;
    spi_byte_t  rx1;
    spi_byte_t  rx2;
    spi_byte_t  rx3;

    // Bus request and response.
    bus_addr_t  pi_addr;
    bus_data_t  pi_data_out;
    logic       pi_rw_b;
    logic       pi_pending_out;
    logic       bus_done;
    bus_data_t  rd_data;

    // RAM port.
    logic                  ram_we;
    logic [RAM_ADDR_W-1:0] ram_addr;
    bus_data_t             ram_wr_data;
    bus_data_t             ram_rd_data;

    spi_buffer spi_buffer_i (
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_rx   (spi_rx),
        .spi_tx   (spi_tx),
        .length   (length),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .rx0      (rx0),
        .rx1      (rx1),
        .rx2      (rx2),
        .rx3      (rx3),
        .valid    (valid)
    );

    pi_com pi_com_i (
        .rst_n          (rst_n),
        .spi_sclk       (spi_sclk),
        .pi_pending_in  (pi_pending_in),
        .valid          (valid),
        .rx0            (rx0),
        .rx1            (rx1),
        .rx2            (rx2),
        .rx3            (rx3),
        .pi_done_in     (bus_done),
        .rd_data        (rd_data),
        .length         (length),
        .tx_load        (tx_load),
        .tx_byte        (tx_byte),
        .pi_addr        (pi_addr),
        .pi_data_out    (pi_data_out),
        .pi_rw_b        (pi_rw_b),
        .pi_pending_out (pi_pending_out),
        .pi_done_out    (pi_done_out)
    );

    bus_target #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) bus_target_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pi_pending_out (pi_pending_out),
        .pi_rw_b        (pi_rw_b),
        .pi_addr        (pi_addr),
        .pi_data_out    (pi_data_out),
        .ram_rd_data    (ram_rd_data),
        .bus_done       (bus_done),
        .rd_data        (rd_data),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wr_data    (ram_wr_data)
    );

    pet_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) pet_ram_i (
        .clk     (clk),
        .we      (ram_we),
        .addr    (ram_addr),
        .wr_data (ram_wr_data),
        .rd_data (ram_rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/pi_bridge_tb.sv ====
// PET bridge directed testbench
`timescale 1ns/100ps
`default_nettype none

module pi_bridge_tb import pi_com_pkg::*; ();

    localparam int RAM_ADDR_W = 12;
    localparam int DONE_LIMIT = 64;
    // About 90 transactions of under 200 clk cycles each, with ample margin.
    localparam int TIMEOUT_CYCLES = 40000;
    localparam logic [31:0] SEED = 32'ha952_b32c;

    logic clk = 1'b0;
    logic rst_n;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_rx;
    logic spi_tx;
    logic pi_pending_in;
    logic pi_done_out;

    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    logic [31:0] rng_state;
    // Reference memory, indexed by the address modulo the RAM size.
    bus_data_t   model_mem [2 ** RAM_ADDR_W];

    pi_bridge_top #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .spi_sclk      (spi_sclk),
        .spi_cs_n      (spi_cs_n),
        .spi_rx        (spi_rx),
        .spi_tx        (spi_tx),
        .pi_pending_in (pi_pending_in),
        .pi_done_out   (pi_done_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_byte(input string what, input bus_data_t got, input bus_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s returned %02h, expected %02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_done(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s saw done %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    // One mode 0 bit, 32 ns period. MOSI changes in the low phase.
    task automatic sclk_bit(input logic mosi, output logic miso, output logic done_lvl);
        @(posedge clk);
        spi_rx <= mosi;
        @(posedge clk);
        spi_sclk <= 1'b1;
        @(posedge clk);
        miso = spi_tx;
        done_lvl = pi_done_out;
        @(posedge clk);
        spi_sclk <= 1'b0;
    endtask

    task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
        logic miso;
        logic lvl;
        rx = '0;
        for (int b = 7; b >= 0; b--) begin
            sclk_bit(tx[b], miso, lvl);
            rx = {rx[6:0], miso};
        end
    endtask

    // Bytes go out from the top of frame; arm drops after drop_after bytes if nonzero.
    task automatic spi_frame(input logic [31:0] frame, input int nbytes, input int drop_after,
                             output spi_byte_t first_rx);
        spi_byte_t rx;
        first_rx = '0;
        @(posedge clk);
        spi_cs_n <= 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            spi_byte(frame[31 - 8 * i -: 8], rx);
            if (i == 0) begin
                first_rx = rx;
            end
            if (i + 1 == drop_after) begin
                @(posedge clk);
                pi_pending_in <= 1'b0;
            end
        end
        @(posedge clk);
        spi_cs_n <= 1'b1;
    endtask

    // Idle clocks with chip select high until done, or until the limit.
    task automatic await_done(input int limit, output logic seen);
        logic miso;
        logic lvl;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            sclk_bit(1'b0, miso, lvl);
            seen = lvl;
        end
    endtask

    // Idle edges after the drop move the read byte into the shifter.
    task automatic release_arm();
        logic miso;
        logic lvl;
        @(posedge clk);
        pi_pending_in <= 1'b0;
        repeat (2) sclk_bit(1'b0, miso, lvl);
    endtask

    task automatic do_write(input bus_addr_t addr, input bus_data_t data);
        spi_byte_t unused;
        logic      seen;
        @(posedge clk);
        pi_pending_in <= 1'b1;
        spi_frame({1'b0, addr[16], CMD_ACCESS, addr[15:8], addr[7:0], data}, 4, 0, unused);
        await_done(DONE_LIMIT, seen);
        check_done($sformatf("write of %05h", addr), seen, 1'b1);
        release_arm();
        model_mem[addr[RAM_ADDR_W-1:0]] = data;
    endtask

    // The result comes back in the first byte of a following frame.
    task automatic do_read(input bus_addr_t addr, output bus_data_t data);
        spi_byte_t unused;
        logic      seen;
        @(posedge clk);
        pi_pending_in <= 1'b1;
        spi_frame({1'b1, addr[16], CMD_ACCESS, addr[15:8], addr[7:0], 8'h00}, 3, 0, unused);
        await_done(DONE_LIMIT, seen);
        check_done($sformatf("read of %05h", addr), seen, 1'b1);
        release_arm();
        spi_frame(32'h0, 1, 0, data);
    endtask

    task automatic read_expect(input bus_addr_t addr);
        bus_data_t got;
        do_read(addr, got);
        check_byte($sformatf("read of %05h", addr), got, model_mem[addr[RAM_ADDR_W-1:0]]);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_write_read();
        int errs;
        errs = error_count;
        do_write(17'h00123, 8'h5a);
        read_expect(17'h00123);
        do_write(17'h00fff, 8'ha5);
        read_expect(17'h00fff);
        read_expect(17'h00123);
        report_test("write_read", errs);
    endtask

    task automatic test_aliasing();
        int errs;
        errs = error_count;
        do_write(17'h00456, 8'hc3);
        read_expect(17'h10456);
        read_expect(17'h0f456);
        do_write(17'h1a456, 8'h3c);
        read_expect(17'h00456);
        report_test("aliasing", errs);
    endtask

    task automatic test_unknown_cmd();
        int        errs;
        logic      seen;
        spi_byte_t unused;
        errs = error_count;
        do_write(17'h00200, 8'h11);
        @(posedge clk);
        pi_pending_in <= 1'b1;
        // Code 0x3f with a write payload that must not land.
        spi_frame({8'h3f, 8'h02, 8'h00, 8'hee}, 4, 0, unused);
        await_done(DONE_LIMIT, seen);
        check_done("unknown command", seen, 1'b0);
        release_arm();
        read_expect(17'h00200);
        report_test("unknown_cmd", errs);
    endtask

    task automatic test_abort();
        int        errs;
        logic      seen;
        spi_byte_t unused;
        errs = error_count;
        do_write(17'h00300, 8'h77);
        @(posedge clk);
        pi_pending_in <= 1'b1;
        spi_frame({1'b0, 1'b0, CMD_ACCESS, 8'h03, 8'h00, 8'h99}, 4, 2, unused);
        await_done(16, seen);
        check_done("aborted write", seen, 1'b0);
        release_arm();
        read_expect(17'h00300);
        report_test("abort", errs);
    endtask

    task automatic test_random();
        int        errs;
        bus_addr_t addrs [30];
        errs = error_count;
        for (int i = 0; i < 30; i++) begin
            rng_state = xorshift(rng_state);
            addrs[i] = rng_state[16:0];
            do_write(addrs[i], rng_state[31:24]);
        end
        for (int i = 0; i < 30; i++) begin
            read_expect(addrs[i]);
        end
        report_test("random", errs);
    endtask

    initial begin
        rst_n         <= 1'b0;
        spi_sclk      <= 1'b0;
        spi_cs_n      <= 1'b1;
        spi_rx        <= 1'b0;
        pi_pending_in <= 1'b0;
        rng_state = SEED;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_write_read();
        test_aliasing();
        test_unknown_cmd();
        test_abort();
        test_random();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/pi_com_pkg.sv
design/spi_buffer.sv
design/pi_com.sv
design/bus_target.sv
design/pet_ram.sv
design/pi_bridge_top.sv
dv/pi_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module pi_bridge_tb \
    -f compile.f -o pi_bridge_sim \
    && ./obj_dir/pi_bridge_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
